// ==== bench/dbg_checker.sv ====
module dbg_checker
	import dbg_pkg::*;
#(
	parameter int NUM_REGS = NUM_REGS_DEF
) (
	input  logic       clk,
	input  logic       rst_n,
	input  word_t      sw,
	input  word_t      led_data,
	input  cpu_probe_t probe,
	input  reg_wr_t    reg_wr,
	input  logic [2:0] rd_addr1,
	input  logic [2:0] rd_addr2,
	input  word_t      rd_value1,
	input  word_t      rd_value2,
	input  axil_req_t  axil_req,
	input  axil_rsp_t  axil_rsp,
	input  int         test_id,
	input  logic       done,
	output int         errors,
	output int         checks
);
	timeunit 1ns;
	timeprecision 1ps;

	word_t [NUM_REGS-1:0] m_regs;
	word_t [NUM_REGS-1:0] m_reg_view;
	cpu_probe_t           m_probe_view;
	logic                 m_override;
	logic                 m_host_freeze;
	logic                 m_bp_en;
	logic                 m_hit;
	page_t                m_page;
	word_t                m_bp_pc;
	logic                 m_bvalid;
	logic                 m_rvalid;
	logic [1:0]           m_bresp;
	logic [1:0]           m_rresp;
	logic [31:0]          m_rdata;
	word_t                led_exp;
	int                   cur_id;
	int                   t_checks;
	int                   t_errors;
	logic                 reported;

	////////////////////////////////////////////////////////////////////////////
	// Reference for the LED word

	function automatic word_t expected_led(page_t pg, word_t sw_v, cpu_probe_t pv,
			word_t [NUM_REGS-1:0] rv);
		word_t      fields [10];
		logic [7:0] fl;
		word_t      led;
		fields = '{pv.if_pc, pv.if_inst, pv.id_pc, pv.id_inst, pv.alu_op1,
			pv.alu_op2, pv.alu_res, pv.wb_res, pv.mem_addr, pv.mem_data};
		fl  = pv.flags;
		led = sw_v;
		if (pg == PAGE_FLAGS) begin
			led = '0;
			// Flag bit i lands on LED 2i+1, spare bit unused
			for (int i = 1; i < 8; i++) begin
				led[2*i+1] = fl[i];
			end
		end
		for (int i = 0; i < 10; i++) begin
			if (int'(pg) == int'(PAGE_IF_PC) + i) begin
				led = fields[i];
			end
		end
		for (int i = 0; i < NUM_REGS; i++) begin
			if (int'(pg) == int'(PAGE_REG_BASE) + i) begin
				led = rv[i];
			end
		end
		return led;
	endfunction

	function automatic string test_name(int id);
		case (id)
			1:       return "switch pages";
			2:       return "register file";
			3:       return "page override";
			4:       return "host freeze";
			5:       return "breakpoint";
			6:       return "unmapped access";
			default: return "idle";
		endcase
	endfunction

	task automatic compare_value(string name, logic [31:0] exp, logic [31:0] got);
		checks++;
		t_checks++;
		if (got !== exp) begin
			errors++;
			t_errors++;
			$display("MISMATCH %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic print_test_line();
		$display("test %0d (%s): %0d checks, %0d mismatches", cur_id, test_name(cur_id),
			t_checks, t_errors);
	endtask

	task automatic reset_model();
		m_regs        = '0;
		m_reg_view    = '0;
		m_probe_view  = '0;
		m_override    = 1'b0;
		m_host_freeze = 1'b0;
		m_bp_en       = 1'b0;
		m_hit         = 1'b0;
		m_page        = '0;
		m_bp_pc       = '0;
		m_bvalid      = 1'b0;
		m_rvalid      = 1'b0;
		errors        = 0;
		checks        = 0;
		cur_id        = 0;
		t_checks      = 0;
		t_errors      = 0;
		reported      = 1'b0;
	endtask

	task automatic track_tests();
		if (test_id != cur_id) begin
			if (cur_id != 0) begin
				print_test_line();
			end
			cur_id   = test_id;
			t_checks = 0;
			t_errors = 0;
		end
		if (done && !reported) begin
			print_test_line();
			$display("%0d checks, %0d mismatches", checks, errors);
			reported = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare, then step the model like the flops

	task automatic check_cycle();
		page_t pg;
		word_t e1;
		word_t e2;
		pg      = m_override ? m_page : sw[15:8];
		led_exp = expected_led(pg, sw, m_probe_view, m_reg_view);
		compare_value("led_data", 32'(led_exp), 32'(led_data));
		e1 = '0;
		e2 = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			if (int'(rd_addr1) == i) begin
				e1 = m_regs[i];
			end
			if (int'(rd_addr2) == i) begin
				e2 = m_regs[i];
			end
		end
		compare_value("rd_value1", 32'(e1), 32'(rd_value1));
		compare_value("rd_value2", 32'(e2), 32'(rd_value2));
		compare_value("axil_rsp.awready",
			32'(axil_req.awvalid && axil_req.wvalid && !m_bvalid), 32'(axil_rsp.awready));
		compare_value("axil_rsp.wready",
			32'(axil_req.awvalid && axil_req.wvalid && !m_bvalid), 32'(axil_rsp.wready));
		compare_value("axil_rsp.arready", 32'(axil_req.arvalid && !m_rvalid),
			32'(axil_rsp.arready));
		compare_value("axil_rsp.bvalid", 32'(m_bvalid), 32'(axil_rsp.bvalid));
		compare_value("axil_rsp.rvalid", 32'(m_rvalid), 32'(axil_rsp.rvalid));
		if (m_bvalid && axil_req.bready) begin
			compare_value("axil_rsp.bresp", 32'(m_bresp), 32'(axil_rsp.bresp));
		end
		if (m_rvalid && axil_req.rready) begin
			compare_value("axil_rsp.rresp", 32'(m_rresp), 32'(axil_rsp.rresp));
			compare_value("axil_rsp.rdata", m_rdata, axil_rsp.rdata);
		end
	endtask

	task automatic advance_model();
		logic        wr_go;
		logic        rd_go;
		logic        frz;
		logic        bp_match;
		logic        ok;
		logic [31:0] rword;
		wr_go    = axil_req.awvalid && axil_req.wvalid && !m_bvalid;
		rd_go    = axil_req.arvalid && !m_rvalid;
		frz      = m_host_freeze || m_hit;
		bp_match = m_bp_en && (probe.if_pc == m_bp_pc);
		if (rd_go) begin
			ok    = 1'b1;
			rword = '0;
			case (axil_req.araddr)
				8'h00:   rword = {29'd0, m_bp_en, m_host_freeze, m_override};
				8'h04:   rword = {24'd0, m_page};
				8'h08:   rword = {16'd0, m_bp_pc};
				8'h0C:   rword = {15'd0, frz, led_exp};
				default: ok = 1'b0;
			endcase
			m_rdata = rword;
			m_rresp = ok ? 2'b00 : 2'b10;
		end
		// Views take the values from before this edge
		if (!frz) begin
			m_probe_view = probe;
			m_reg_view   = m_regs;
		end
		for (int i = 0; i < NUM_REGS; i++) begin
			if (reg_wr.en && int'(reg_wr.addr) == i) begin
				m_regs[i] = reg_wr.value;
			end
		end
		if (wr_go) begin
			ok = 1'b1;
			case (axil_req.awaddr)
				8'h00: begin
					m_override = axil_req.wdata[0];
					m_bp_en    = axil_req.wdata[2];
					if (axil_req.wdata[3]) begin
						m_host_freeze = 1'b0;
						m_hit         = 1'b0;
					end else begin
						m_host_freeze = axil_req.wdata[1];
					end
				end
				8'h04:   m_page = axil_req.wdata[7:0];
				8'h08:   m_bp_pc = axil_req.wdata[15:0];
				8'h0C:   ok = 1'b1;
				default: ok = 1'b0;
			endcase
			m_bresp = ok ? 2'b00 : 2'b10;
		end
		if (bp_match) begin
			m_hit = 1'b1;
		end
		m_bvalid = wr_go || (m_bvalid && !axil_req.bready);
		m_rvalid = rd_go || (m_rvalid && !axil_req.rready);
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_model();
		end else begin
			track_tests();
			check_cycle();
			advance_model();
		end
	end

endmodule

// ==== bench/tb_dbg_panel.sv ====
module tb_dbg_panel
	import dbg_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_REGS   = NUM_REGS_DEF;
	localparam int ADDR_W     = 8;
	localparam int CLK_PERIOD = 20;
	localparam int RAND_STEPS = 24;
	localparam int HS_LIMIT   = 32;
	// Upper bound on drive and AXI steps over all tests
	localparam int TEST_STEPS      = 12 * RAND_STEPS;
	localparam int WATCHDOG_CYCLES = TEST_STEPS * 40 + 1000;

	logic       clk = 1'b0;
	logic       rst_n;
	word_t      sw;
	word_t      led_data;
	cpu_probe_t probe;
	reg_wr_t    reg_wr;
	logic [2:0] rd_addr1;
	logic [2:0] rd_addr2;
	word_t      rd_value1;
	word_t      rd_value2;
	axil_req_t  axil_req;
	axil_rsp_t  axil_rsp;
	int         test_id;
	logic       done;
	int         errors;
	int         checks;
	int         faults;
	int         seed;
	word_t      pc_next;
	word_t      bp;

	always #(CLK_PERIOD / 2) clk = ~clk;

	dbg_panel_top #(
		.NUM_REGS(NUM_REGS),
		.ADDR_W  (ADDR_W)
	) i_dbg_panel_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.sw       (sw),
		.led_data (led_data),
		.probe    (probe),
		.reg_wr   (reg_wr),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.rd_value1(rd_value1),
		.rd_value2(rd_value2),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp)
	);

	dbg_checker #(
		.NUM_REGS(NUM_REGS)
	) i_dbg_checker (
		.clk      (clk),
		.rst_n    (rst_n),
		.sw       (sw),
		.led_data (led_data),
		.probe    (probe),
		.reg_wr   (reg_wr),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.rd_value1(rd_value1),
		.rd_value2(rd_value2),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.test_id  (test_id),
		.done     (done),
		.errors   (errors),
		.checks   (checks)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	// Random probe with a fetch PC that walks up by one instruction
	function automatic cpu_probe_t next_probe();
		logic [191:0] raw;
		cpu_probe_t   p;
		for (int i = 0; i < 6; i++) begin
			raw[i*32 +: 32] = $random(seed);
		end
		p       = raw[167:0];
		p.if_pc = pc_next;
		pc_next = pc_next + 16'd2;
		return p;
	endfunction

	function automatic page_t pick_page();
		logic [31:0] r;
		r = $random(seed);
		if (r[1:0] == 2'd0) begin
			return PAGE_REG_BASE + 8'(r[4:2]);
		end else if (r[1:0] == 2'd1) begin
			return 8'(r[7:4]);
		end else begin
			return r[15:8];
		end
	endfunction

	function automatic page_t reg_page(int i);
		return page_t'(int'(PAGE_REG_BASE) + (i % NUM_REGS));
	endfunction

	task automatic note_fault(string msg);
		faults++;
		$display("%s at %0t", msg, $time);
	endtask

	task automatic start_test(int id);
		@(posedge clk);
		test_id <= id;
	endtask

	task automatic drive_cycle(input page_t pg, input logic wr_en);
		logic [31:0] r1;
		logic [31:0] r2;
		cpu_probe_t  p;
		r1 = $random(seed);
		r2 = $random(seed);
		p  = next_probe();
		@(posedge clk);
		sw       <= {pg, r1[7:0]};
		probe    <= p;
		reg_wr   <= '{en: wr_en, addr: r1[10:8], value: r1[31:16]};
		rd_addr1 <= r2[2:0];
		rd_addr2 <= r2[5:3];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// AXI4-Lite master

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
		int waited;
		@(posedge clk);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr  <= addr;
		axil_req.wvalid  <= 1'b1;
		axil_req.wdata   <= data;
		axil_req.wstrb   <= 4'hF;
		axil_req.bready  <= 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!axil_rsp.awready && waited < HS_LIMIT);
		if (!axil_rsp.awready) begin
			note_fault($sformatf("AXI write to 0x%02h was never accepted", addr));
		end
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!axil_rsp.bvalid && waited < HS_LIMIT);
		if (!axil_rsp.bvalid) begin
			note_fault($sformatf("AXI write to 0x%02h got no response", addr));
		end
		axil_req.bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr);
		int waited;
		@(posedge clk);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr  <= addr;
		axil_req.rready  <= 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!axil_rsp.arready && waited < HS_LIMIT);
		if (!axil_rsp.arready) begin
			note_fault($sformatf("AXI read of 0x%02h was never accepted", addr));
		end
		axil_req.arvalid <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!axil_rsp.rvalid && waited < HS_LIMIT);
		if (!axil_rsp.rvalid) begin
			note_fault($sformatf("AXI read of 0x%02h got no data", addr));
		end
		axil_req.rready <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed     = 32'h3793_d32b;
		rst_n    = 1'b0;
		sw       = '0;
		probe    = '0;
		reg_wr   = '0;
		rd_addr1 = '0;
		rd_addr2 = '0;
		axil_req = '0;
		test_id  = 0;
		done     = 1'b0;
		faults   = 0;
		pc_next  = word_t'($random(seed));
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		start_test(1);
		// Flags page, every probe word page and the first unmapped code
		for (int i = 0; i <= int'(PAGE_MEM_DATA) + 1; i++) begin
			drive_cycle(page_t'(i), 1'b0);
		end
		// First code past the last register page
		drive_cycle(page_t'(int'(PAGE_REG_BASE) + NUM_REGS), 1'b0);
		for (int i = 0; i < 2 * RAND_STEPS; i++) begin
			drive_cycle(pick_page(), 1'b0);
		end

		start_test(2);
		for (int i = 0; i < RAND_STEPS; i++) begin
			drive_cycle(reg_page(i), 1'b1);
		end
		for (int i = 0; i < NUM_REGS; i++) begin
			drive_cycle(reg_page(i), 1'b0);
		end

		start_test(3);
		axi_write(8'h04, {24'd0, PAGE_ALU_OP1});
		axi_write(8'h00, 32'h1);
		axi_read(8'h00);
		axi_read(8'h04);
		for (int i = 0; i < RAND_STEPS; i++) begin
			drive_cycle(pick_page(), 1'b0);
		end
		axi_write(8'h04, {24'd0, reg_page(3)});
		axi_read(8'h04);
		for (int i = 0; i < 8; i++) begin
			drive_cycle(pick_page(), 1'b1);
		end
		axi_write(8'h00, 32'h0);

		start_test(4);
		drive_cycle(PAGE_ALU_RES, 1'b0);
		drive_cycle(PAGE_ALU_RES, 1'b0);
		axi_write(8'h00, 32'h2);
		for (int i = 0; i < RAND_STEPS; i++) begin
			drive_cycle(pick_page(), 1'b1);
		end
		axi_read(8'h0C);
		axi_write(8'h00, 32'h8);
		for (int i = 0; i < 8; i++) begin
			drive_cycle(pick_page(), 1'b0);
		end

		// Breakpoint sits six fetches ahead of the stream
		start_test(5);
		bp = pc_next + 16'd10;
		axi_write(8'h08, {16'd0, bp});
		axi_write(8'h00, 32'h4);
		for (int i = 0; i < RAND_STEPS; i++) begin
			drive_cycle(PAGE_IF_PC, 1'b1);
		end
		axi_read(8'h0C);
		axi_write(8'h00, 32'h8);
		for (int i = 0; i < 8; i++) begin
			drive_cycle(pick_page(), 1'b0);
		end

		start_test(6);
		axi_write(8'h10, 32'hFFFF_FFFF);
		axi_write(8'h02, 32'h0000_0007);
		axi_read(8'h10);
		axi_read(8'h0E);
		axi_read(8'h00);
		axi_read(8'h04);
		axi_read(8'h08);
		for (int i = 0; i < 4; i++) begin
			drive_cycle(pick_page(), 1'b0);
		end

		@(posedge clk);
		done <= 1'b1;
		repeat (3) @(posedge clk);
		if (errors == 0 && faults == 0 && checks > 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
src/dbg_pkg.sv
src/cpu_regfile.sv
src/probe_snapshot.sv
src/dbg_csr.sv
src/led_page_mux.sv
src/dbg_panel_top.sv
bench/dbg_checker.sv
bench/tb_dbg_panel.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_dbg_panel -o vsim_dbg_panel
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/vsim_dbg_panel)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== src/cpu_regfile.sv ====
module cpu_regfile
	import dbg_pkg::*;
#(
	parameter int NUM_REGS = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  reg_wr_t              wr,
	input  logic [2:0]           rd_addr1,
	input  logic [2:0]           rd_addr2,
	output word_t                rd_value1,
	output word_t                rd_value2,
	output word_t [NUM_REGS-1:0] dump
);

	word_t [NUM_REGS-1:0] regs;
	logic                 wr_in_range;
	logic                 rd1_in_range;
	logic                 rd2_in_range;

	assign wr_in_range  = int'(wr.addr) < NUM_REGS;
	assign rd1_in_range = int'(rd_addr1) < NUM_REGS;
	assign rd2_in_range = int'(rd_addr2) < NUM_REGS;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '0;
		end else if (wr.en && wr_in_range) begin
			regs[wr.addr] <= wr.value;
		end
	end

	// No write bypass, reads show what is stored
	always_comb begin
		rd_value1 = '0;
		rd_value2 = '0;
		if (rd1_in_range) begin
			rd_value1 = regs[rd_addr1];
		end
		if (rd2_in_range) begin
			rd_value2 = regs[rd_addr2];
		end
	end

	// Register i sits in word i of the dump
	assign dump = regs;

	wr_addr_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr.en |-> wr_in_range
	);

endmodule

// ==== src/dbg_csr.sv ====
module dbg_csr
	import dbg_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  axil_req_t req,
	output axil_rsp_t rsp,
	input  word_t     live_pc,
	input  word_t     led_data,
	input  page_t     sw_page,
	output page_t     page,
	output logic      freeze
);

	localparam logic [ADDR_W-1:0] ADDR_CTRL   = ADDR_W'(8'h0);
	localparam logic [ADDR_W-1:0] ADDR_PAGE   = ADDR_W'(8'h4);
	localparam logic [ADDR_W-1:0] ADDR_BP_PC  = ADDR_W'(8'h8);
	localparam logic [ADDR_W-1:0] ADDR_STATUS = ADDR_W'(8'hC);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic              ctrl_override;
	logic              ctrl_freeze;
	logic              ctrl_bp_en;
	logic              hit;
	page_t             page_q;
	word_t             bp_pc;
	logic              bp_match;

	logic              wr_go;
	logic              rd_go;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	logic              wr_ok;
	logic              rd_ok;
	logic [31:0]       rd_word;

	logic              bvalid;
	logic [1:0]        bresp;
	logic              rvalid;
	logic [1:0]        rresp;
	logic [31:0]       rdata;

	////////////////////////////////////////////////////////////////////////////
	// Handshake and decode

	// Both channels accepted together, never with a response pending
	assign wr_go   = req.awvalid && req.wvalid && !bvalid;
	assign rd_go   = req.arvalid && !rvalid;
	assign wr_addr = req.awaddr[ADDR_W-1:0];
	assign rd_addr = req.araddr[ADDR_W-1:0];
	assign wr_ok   = wr_addr inside {ADDR_CTRL, ADDR_PAGE, ADDR_BP_PC, ADDR_STATUS};

	always_comb begin
		rd_word = '0;
		rd_ok   = 1'b1;
		case (rd_addr)
			ADDR_CTRL:   rd_word = {29'd0, ctrl_bp_en, ctrl_freeze, ctrl_override};
			ADDR_PAGE:   rd_word = {24'd0, page_q};
			ADDR_BP_PC:  rd_word = {16'd0, bp_pc};
			ADDR_STATUS: rd_word = {15'd0, freeze, led_data};
			default:     rd_ok = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Control registers and breakpoint

	assign bp_match = ctrl_bp_en && (live_pc == bp_pc);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_override <= 1'b0;
			ctrl_freeze   <= 1'b0;
			ctrl_bp_en    <= 1'b0;
			hit           <= 1'b0;
			page_q        <= '0;
			bp_pc         <= '0;
		end else begin
			if (wr_go) begin
				case (wr_addr)
					ADDR_CTRL: begin
						if (req.wstrb[0]) begin
							ctrl_override <= req.wdata[0];
							ctrl_bp_en    <= req.wdata[2];
							// Unfreeze wins over a host freeze in the same word
							if (req.wdata[3]) begin
								ctrl_freeze <= 1'b0;
								hit         <= 1'b0;
							end else begin
								ctrl_freeze <= req.wdata[1];
							end
						end
					end
					ADDR_PAGE: begin
						if (req.wstrb[0]) begin
							page_q <= req.wdata[7:0];
						end
					end
					ADDR_BP_PC: begin
						if (req.wstrb[0]) begin
							bp_pc[7:0] <= req.wdata[7:0];
						end
						if (req.wstrb[1]) begin
							bp_pc[15:8] <= req.wdata[15:8];
						end
					end
					default: begin
					end
				endcase
			end
			// A match on this edge outranks a clear
			if (bp_match) begin
				hit <= 1'b1;
			end
		end
	end

	assign freeze = ctrl_freeze || hit;
	assign page   = ctrl_override ? page_q : sw_page;

	////////////////////////////////////////////////////////////////////////////
	// Responses

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_go) begin
				bvalid <= 1'b1;
			end else if (req.bready) begin
				bvalid <= 1'b0;
			end
			if (rd_go) begin
				rvalid <= 1'b1;
			end else if (req.rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go) begin
			bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
		if (rd_go) begin
			rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
			rdata <= rd_word;
		end
	end

	always_comb begin
		rsp.awready = wr_go;
		rsp.wready  = wr_go;
		rsp.bvalid  = bvalid;
		rsp.bresp   = bresp;
		rsp.arready = rd_go;
		rsp.rvalid  = rvalid;
		rsp.rdata   = rdata;
		rsp.rresp   = rresp;
	end

	b_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp)
	);

	r_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata)
	);

endmodule

// ==== src/dbg_panel_top.sv ====
module dbg_panel_top
	import dbg_pkg::*;
#(
	parameter int NUM_REGS = NUM_REGS_DEF,
	parameter int ADDR_W   = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  word_t      sw,
	output word_t      led_data,
	input  cpu_probe_t probe,
	input  reg_wr_t    reg_wr,
	input  logic [2:0] rd_addr1,
	input  logic [2:0] rd_addr2,
	output word_t      rd_value1,
	output word_t      rd_value2,
	input  axil_req_t  axil_req,
	output axil_rsp_t  axil_rsp
);

	typedef word_t [NUM_REGS-1:0] reg_dump_t;

	reg_dump_t  reg_live;
	reg_dump_t  reg_view;
	cpu_probe_t probe_view;
	page_t      page;
	logic       freeze;

	cpu_regfile #(
		.NUM_REGS(NUM_REGS)
	) i_cpu_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (reg_wr),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.rd_value1(rd_value1),
		.rd_value2(rd_value2),
		.dump     (reg_live)
	);

	////////////////////////////////////////////////////////////////////////////
	// Frozen view, both snapshots share one freeze level

	probe_snapshot #(
		.payload_t(reg_dump_t)
	) i_reg_snapshot (
		.clk   (clk),
		.rst_n (rst_n),
		.freeze(freeze),
		.live  (reg_live),
		.view  (reg_view)
	);

	probe_snapshot #(
		.payload_t(cpu_probe_t)
	) i_probe_snapshot (
		.clk   (clk),
		.rst_n (rst_n),
		.freeze(freeze),
		.live  (probe),
		.view  (probe_view)
	);

	// Breakpoint compares against the live fetch PC
	dbg_csr #(
		.ADDR_W(ADDR_W)
	) i_dbg_csr (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (axil_req),
		.rsp     (axil_rsp),
		.live_pc (probe.if_pc),
		.led_data(led_data),
		.sw_page (sw[15:8]),
		.page    (page),
		.freeze  (freeze)
	);

	led_page_mux #(
		.NUM_REGS(NUM_REGS)
	) i_led_page_mux (
		.page    (page),
		.sw      (sw),
		.probe   (probe_view),
		.regs    (reg_view),
		.led_data(led_data)
	);

endmodule

// ==== src/dbg_pkg.sv ====
package dbg_pkg;

	typedef logic [15:0] word_t;
	typedef logic [7:0]  page_t;

	// One bit per pipeline flag, spare pads to a byte
	typedef struct packed {
		logic stall;
		logic flush;
		logic mem_rd;
		logic mem_wr;
		logic wb_en;
		logic alu_flag;
		logic decoder_error;
		logic spare;
	} probe_flags_t;

	// Order matches the page codes 0x01 to 0x0A
	typedef struct packed {
		word_t        if_pc;
		word_t        if_inst;
		word_t        id_pc;
		word_t        id_inst;
		word_t        alu_op1;
		word_t        alu_op2;
		word_t        alu_res;
		word_t        wb_res;
		word_t        mem_addr;
		word_t        mem_data;
		probe_flags_t flags;
	} cpu_probe_t;

	typedef struct packed {
		logic       en;
		logic [2:0] addr;
		word_t      value;
	} reg_wr_t;

	// Master side of AXI4-Lite
	typedef struct packed {
		logic        awvalid;
		logic [7:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [7:0]  araddr;
		logic        rready;
	} axil_req_t;

	// Slave side of AXI4-Lite
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	localparam page_t PAGE_FLAGS    = 8'h00;
	localparam page_t PAGE_IF_PC    = 8'h01;
	localparam page_t PAGE_IF_INST  = 8'h02;
	localparam page_t PAGE_ID_PC    = 8'h03;
	localparam page_t PAGE_ID_INST  = 8'h04;
	localparam page_t PAGE_ALU_OP1  = 8'h05;
	localparam page_t PAGE_ALU_OP2  = 8'h06;
	localparam page_t PAGE_ALU_RES  = 8'h07;
	localparam page_t PAGE_WB_RES   = 8'h08;
	localparam page_t PAGE_MEM_ADDR = 8'h09;
	localparam page_t PAGE_MEM_DATA = 8'h0A;
	localparam page_t PAGE_REG_BASE = 8'h30;

	localparam int NUM_REGS_DEF = 8;

endpackage

// ==== src/led_page_mux.sv ====
module led_page_mux
	import dbg_pkg::*;
#(
	parameter int NUM_REGS = 8
) (
	input  page_t                page,
	input  word_t                sw,
	input  cpu_probe_t           probe,
	input  word_t [NUM_REGS-1:0] regs,
	output word_t                led_data
);

	probe_flags_t f;
	page_t        reg_idx;
	logic         reg_page;

	assign f        = probe.flags;
	assign reg_idx  = page - PAGE_REG_BASE;
	assign reg_page = (page >= PAGE_REG_BASE) && (int'(reg_idx) < NUM_REGS);

	////////////////////////////////////////////////////////////////////////////
	// Page select

	always_comb begin
		case (page)
			// Every flag followed by a dark LED
			PAGE_FLAGS: begin
				led_data = {f.stall, 1'b0, f.flush, 1'b0, f.mem_rd, 1'b0,
					f.mem_wr, 1'b0, f.wb_en, 1'b0, f.alu_flag, 1'b0,
					f.decoder_error, 1'b0, 2'b00};
			end
			PAGE_IF_PC:    led_data = probe.if_pc;
			PAGE_IF_INST:  led_data = probe.if_inst;
			PAGE_ID_PC:    led_data = probe.id_pc;
			PAGE_ID_INST:  led_data = probe.id_inst;
			PAGE_ALU_OP1:  led_data = probe.alu_op1;
			PAGE_ALU_OP2:  led_data = probe.alu_op2;
			PAGE_ALU_RES:  led_data = probe.alu_res;
			PAGE_WB_RES:   led_data = probe.wb_res;
			PAGE_MEM_ADDR: led_data = probe.mem_addr;
			PAGE_MEM_DATA: led_data = probe.mem_data;
			default: begin
				// Register pages, switches everywhere else
				if (reg_page) begin
					led_data = regs[reg_idx];
				end else begin
					led_data = sw;
				end
			end
		endcase
	end

endmodule

// ==== src/probe_snapshot.sv ====
module probe_snapshot #(
	parameter type payload_t = logic [15:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     freeze,
	input  payload_t live,
	output payload_t view
);

	// Tracks live with one cycle of lag, holds while frozen
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			view <= '0;
		end else if (!freeze) begin
			view <= live;
		end
	end

	// Freeze sampled high means the next view equals the current one
	view_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		freeze |=> $stable(view)
	);

endmodule
